/* include/dtu_config.svh */
`ifndef DTU_CONFIG_SVH
`define DTU_CONFIG_SVH

// Data path widths
`define DTU_XLEN            64
`define DTU_PC_WIDTH        40
`define DTU_CSR_ADDR_WIDTH  12
`define DTU_ICOUNT_WIDTH    14

// Debug CSR map
`define DTU_CSR_TDATA1      12'h7a1
`define DTU_CSR_TDATA2      12'h7a2
`define DTU_CSR_ICOUNT      12'h7a3
`define DTU_CSR_DCSR        12'h7b0
`define DTU_CSR_DPC         12'h7b1
`define DTU_CSR_DSCRATCH0   12'h7b2

// tdata1 trigger enable bit
`define DTU_TDATA1_EN       0

// dcsr layout
`define DTU_DCSR_XDEBUGVER  31:28
`define DTU_DCSR_EBREAKM    15
`define DTU_DCSR_STOPCOUNT  10
`define DTU_DCSR_CAUSE      8:6
`define DTU_DCSR_STEP       2
`define DTU_DCSR_PRV        1:0
`define DTU_XDEBUGVER_VAL   4'd4
`define DTU_PRV_RESET       2'd3

// Halt cause codes for dcsr.cause
`define DTU_CAUSE_NONE      3'd0
`define DTU_CAUSE_EBREAK    3'd1
`define DTU_CAUSE_TRIGGER   3'd2
`define DTU_CAUSE_HALTREQ   3'd3
`define DTU_CAUSE_STEP      3'd4

`endif

/* src/dtu_pkg.sv */
`include "dtu_config.svh"

package dtu_pkg;

  // ==============================
  // Vector types
  // ==============================
  typedef logic [`DTU_XLEN-1:0]           xlen_t;
  typedef logic [`DTU_PC_WIDTH-1:0]       pc_t;
  typedef logic [`DTU_CSR_ADDR_WIDTH-1:0] csr_addr_t;
  typedef logic [`DTU_ICOUNT_WIDTH-1:0]   icount_t;

  // ==============================
  // Enums
  // ==============================
  typedef enum logic [2:0] {
    cause_none    = `DTU_CAUSE_NONE,
    cause_ebreak  = `DTU_CAUSE_EBREAK,
    cause_trigger = `DTU_CAUSE_TRIGGER,
    cause_haltreq = `DTU_CAUSE_HALTREQ,
    cause_step    = `DTU_CAUSE_STEP
  } halt_cause_e;

  typedef enum logic [1:0] {
    st_running,
    st_halt_pending,
    st_halted
  } halt_state_e;

  // ==============================
  // Buses
  // ==============================
  // Wishbone classic, debug module side
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    csr_addr_t adr;
    xlen_t     dat_w;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    xlen_t dat_r;
  } wb_rsp_t;

  // One retired instruction from the core
  typedef struct packed {
    logic vld;
    pc_t  pc;
    pc_t  next_pc;
    logic ebreak;
  } retire_t;

  // Live CSR settings fanned out to the other blocks
  typedef struct packed {
    logic step;
    logic ebreakm;
    logic stopcount;
    logic trig_en;
    pc_t  trig_addr;
  } dbg_ctrl_t;

  typedef struct packed {
    logic        vld;
    halt_cause_e cause;
    pc_t         dpc;
  } halt_capture_t;

  // icount write from the CSR port
  typedef struct packed {
    logic    vld;
    icount_t value;
  } icount_load_t;

endpackage

/* src/dtu_csr_file.sv */
`timescale 1ns/1ps
`include "dtu_config.svh"

module dtu_csr_file (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  dtu_pkg::wb_req_t       wb_req,
  output dtu_pkg::wb_rsp_t       wb_rsp,
  input  dtu_pkg::halt_capture_t capture,
  output dtu_pkg::dbg_ctrl_t     ctrl,
  output dtu_pkg::pc_t           dpc,
  output dtu_pkg::icount_load_t  icount_load,
  input  dtu_pkg::icount_t       icount_value
);

  // Bus handshake
  logic                 access;
  logic                 wr_en;
  logic                 served_q;
  logic                 ack_q;
  dtu_pkg::xlen_t       rdata_mux;
  dtu_pkg::xlen_t       rdata_q;
  dtu_pkg::xlen_t       dcsr_rd;

  // dcsr fields
  logic                 dcsr_ebreakm_q;
  logic                 dcsr_stopcount_q;
  logic                 dcsr_step_q;
  logic [1:0]           dcsr_prv_q;
  dtu_pkg::halt_cause_e dcsr_cause_q;

  dtu_pkg::pc_t         dpc_q;
  dtu_pkg::xlen_t       dscratch0_q;
  logic                 tdata1_en_q;
  dtu_pkg::pc_t         tdata2_q;

  // ==============================
  // Wishbone slave handshake
  // ==============================
  // One access per stb assertion, acked on the next edge
  assign access = wb_req.cyc & wb_req.stb & ~served_q;
  assign wr_en  = access & wb_req.we;

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      served_q <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= access;
      if (!wb_req.stb) begin
        served_q <= 1'b0;
      end else if (access) begin
        served_q <= 1'b1;
      end
    end
  end

  // ==============================
  // CSR registers
  // ==============================
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      dcsr_ebreakm_q   <= 1'b0;
      dcsr_stopcount_q <= 1'b0;
      dcsr_step_q      <= 1'b0;
      dcsr_prv_q       <= `DTU_PRV_RESET;
      dcsr_cause_q     <= dtu_pkg::cause_none;
      dpc_q            <= '0;
      tdata1_en_q      <= 1'b0;
      tdata2_q         <= '0;
    end else begin
      if (wr_en) begin
        case (wb_req.adr)
          `DTU_CSR_TDATA1: tdata1_en_q <= wb_req.dat_w[`DTU_TDATA1_EN];
          `DTU_CSR_TDATA2: tdata2_q <= wb_req.dat_w[`DTU_PC_WIDTH-1:0];
          `DTU_CSR_DCSR: begin
            if (!capture.vld) begin
              dcsr_ebreakm_q   <= wb_req.dat_w[`DTU_DCSR_EBREAKM];
              dcsr_stopcount_q <= wb_req.dat_w[`DTU_DCSR_STOPCOUNT];
              dcsr_step_q      <= wb_req.dat_w[`DTU_DCSR_STEP];
              dcsr_prv_q       <= wb_req.dat_w[`DTU_DCSR_PRV];
            end
          end
          `DTU_CSR_DPC: begin
            if (!capture.vld) begin
              dpc_q <= wb_req.dat_w[`DTU_PC_WIDTH-1:0];
            end
          end
          default: ;
        endcase
      end
      // Halt entry from the FSM
      if (capture.vld) begin
        dcsr_cause_q <= capture.cause;
        dpc_q        <= capture.dpc;
      end
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (wr_en && (wb_req.adr == `DTU_CSR_DSCRATCH0)) begin
      dscratch0_q <= wb_req.dat_w;
    end
  end

  // ==============================
  // Read path
  // ==============================
  always_comb begin
    dcsr_rd                       = '0;
    dcsr_rd[`DTU_DCSR_XDEBUGVER]  = `DTU_XDEBUGVER_VAL;
    dcsr_rd[`DTU_DCSR_EBREAKM]    = dcsr_ebreakm_q;
    dcsr_rd[`DTU_DCSR_STOPCOUNT]  = dcsr_stopcount_q;
    dcsr_rd[`DTU_DCSR_CAUSE]      = dcsr_cause_q;
    dcsr_rd[`DTU_DCSR_STEP]       = dcsr_step_q;
    dcsr_rd[`DTU_DCSR_PRV]        = dcsr_prv_q;

    // Unmapped addresses read zero
    rdata_mux = '0;
    case (wb_req.adr)
      `DTU_CSR_TDATA1:    rdata_mux[`DTU_TDATA1_EN] = tdata1_en_q;
      `DTU_CSR_TDATA2:    rdata_mux[`DTU_PC_WIDTH-1:0] = tdata2_q;
      `DTU_CSR_ICOUNT:    rdata_mux[`DTU_ICOUNT_WIDTH-1:0] = icount_value;
      `DTU_CSR_DCSR:      rdata_mux = dcsr_rd;
      `DTU_CSR_DPC:       rdata_mux[`DTU_PC_WIDTH-1:0] = dpc_q;
      `DTU_CSR_DSCRATCH0: rdata_mux = dscratch0_q;
      default: ;
    endcase
  end

  always_ff @(posedge forever_cpuclk) begin
    if (access) begin
      rdata_q <= rdata_mux;
    end
  end

  // ==============================
  // Outputs
  // ==============================
  always_comb begin
    wb_rsp.ack   = ack_q;
    wb_rsp.dat_r = rdata_q;

    ctrl.step      = dcsr_step_q;
    ctrl.ebreakm   = dcsr_ebreakm_q;
    ctrl.stopcount = dcsr_stopcount_q;
    ctrl.trig_en   = tdata1_en_q;
    ctrl.trig_addr = tdata2_q;

    icount_load.vld   = wr_en & (wb_req.adr == `DTU_CSR_ICOUNT);
    icount_load.value = wb_req.dat_w[`DTU_ICOUNT_WIDTH-1:0];
  end

  assign dpc = dpc_q;

endmodule

/* src/dtu_trigger.sv */
`timescale 1ns/1ps

module dtu_trigger (
  input  dtu_pkg::dbg_ctrl_t ctrl,
  input  dtu_pkg::retire_t   retire,
  input  logic               halted,
  output logic               trig_hit
);

  logic pc_match;
  logic armed;

  // ==============================
  // Execute address compare
  // ==============================
  // Full PC compare against tdata2, no mask or range modes
  assign pc_match = (retire.pc == ctrl.trig_addr);

  // No hits while in debug mode
  assign armed = ctrl.trig_en & ~halted;

  // Same cycle as the retirement
  assign trig_hit = armed & retire.vld & pc_match;

endmodule

/* src/dtu_icount.sv */
`timescale 1ns/1ps

module dtu_icount (
  input  logic                  forever_cpuclk,
  input  logic                  arst_n,
  input  dtu_pkg::icount_load_t icount_load,
  input  logic                  resume_step,
  input  logic                  retire_vld,
  output dtu_pkg::icount_t      icount_value,
  output logic                  count_done,
  output logic                  stepping
);

  dtu_pkg::icount_t count_q;
  logic             stepping_q;
  logic             count_last;
  logic             count_live;

  assign count_live = (count_q != '0);
  assign count_last = (count_q == dtu_pkg::icount_t'(1));

  // Fires with the retirement that reaches zero
  assign count_done = retire_vld & count_last;

  // ==============================
  // Counter
  // ==============================
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (icount_load.vld) begin
      count_q <= icount_load.value;
    end else if (resume_step) begin
      // Single step is an icount of one
      count_q <= dtu_pkg::icount_t'(1);
    end else if (retire_vld && count_live) begin
      count_q <= count_q - dtu_pkg::icount_t'(1);
    end
  end

  // Step in progress and interrupt mask for the core
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      stepping_q <= 1'b0;
    end else if (resume_step) begin
      stepping_q <= 1'b1;
    end else if (count_done) begin
      stepping_q <= 1'b0;
    end
  end

  assign icount_value = count_q;
  assign stepping     = stepping_q;

endmodule

/* src/dtu_halt_fsm.sv */
`timescale 1ns/1ps

module dtu_halt_fsm (
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  dtu_pkg::dbg_ctrl_t     ctrl,
  input  dtu_pkg::retire_t       retire,
  input  logic                   trig_hit,
  input  logic                   count_done,
  input  logic                   stepping,
  input  logic                   halt_req_dm,
  input  logic                   resume_req_dm,
  input  logic                   core_halt_ack,
  output logic                   core_halt_req,
  output logic                   core_resume_req,
  output logic                   halted,
  output logic                   resume_step,
  output dtu_pkg::halt_capture_t capture
);

  dtu_pkg::halt_state_e state_q;
  dtu_pkg::halt_state_e state_d;
  dtu_pkg::halt_cause_e event_cause;
  dtu_pkg::halt_cause_e cause_q;
  dtu_pkg::pc_t         event_dpc;
  dtu_pkg::pc_t         dpc_q;
  dtu_pkg::pc_t         last_next_pc_q;
  logic                 event_vld;
  logic                 event_use_last;
  logic                 use_last_q;
  logic                 ebreak_hit;
  logic                 resume_go;
  logic                 resume_q;

  assign ebreak_hit = retire.vld & retire.ebreak & ctrl.ebreakm;
  assign resume_go  = (state_q == dtu_pkg::st_halted) & resume_req_dm;

  // ==============================
  // Halt event priority
  // ==============================
  always_comb begin
    event_vld      = 1'b1;
    event_use_last = 1'b0;
    event_cause    = dtu_pkg::cause_none;
    event_dpc      = retire.pc;
    if (ebreak_hit) begin
      event_cause = dtu_pkg::cause_ebreak;
    end else if (trig_hit) begin
      event_cause = dtu_pkg::cause_trigger;
    end else if (count_done) begin
      // icount expiry counts as a trigger unless single stepping
      event_cause = stepping ? dtu_pkg::cause_step : dtu_pkg::cause_trigger;
      event_dpc   = retire.next_pc;
    end else if (halt_req_dm) begin
      // dpc resolved at the ack from the last retirement
      event_cause    = dtu_pkg::cause_haltreq;
      event_use_last = 1'b1;
    end else begin
      event_vld = 1'b0;
    end
  end

  // ==============================
  // State machine
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      dtu_pkg::st_running:      if (event_vld) state_d = dtu_pkg::st_halt_pending;
      dtu_pkg::st_halt_pending: if (core_halt_ack) state_d = dtu_pkg::st_halted;
      dtu_pkg::st_halted:       if (resume_req_dm) state_d = dtu_pkg::st_running;
      default:                  state_d = dtu_pkg::st_running;
    endcase
  end

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q        <= dtu_pkg::st_running;
      resume_q       <= 1'b0;
      last_next_pc_q <= '0;
    end else begin
      state_q  <= state_d;
      resume_q <= resume_go;
      if (retire.vld) begin
        last_next_pc_q <= retire.next_pc;
      end
    end
  end

  // Cause locked once pending
  always_ff @(posedge forever_cpuclk) begin
    if ((state_q == dtu_pkg::st_running) && event_vld) begin
      cause_q    <= event_cause;
      dpc_q      <= event_dpc;
      use_last_q <= event_use_last;
    end
  end

  // ==============================
  // Outputs
  // ==============================
  assign core_halt_req   = (state_q == dtu_pkg::st_halt_pending);
  assign halted          = (state_q == dtu_pkg::st_halted);
  assign core_resume_req = resume_q;
  assign resume_step     = resume_go & ctrl.step;

  always_comb begin
    capture.vld   = (state_q == dtu_pkg::st_halt_pending) & core_halt_ack;
    capture.cause = cause_q;
    capture.dpc   = use_last_q ? last_next_pc_q : dpc_q;
  end

endmodule

/* src/dtu_top.sv */
`timescale 1ns/1ps

module dtu_top (
  input  logic             forever_cpuclk,
  input  logic             arst_n,
  input  dtu_pkg::wb_req_t wb_req,
  output dtu_pkg::wb_rsp_t wb_rsp,
  input  dtu_pkg::retire_t retire,
  input  logic             halt_req_dm,
  input  logic             resume_req_dm,
  input  logic             core_halt_ack,
  output logic             core_halt_req,
  output logic             core_resume_req,
  output logic             halted,
  output dtu_pkg::pc_t     dpc,
  output logic             int_mask,
  output logic             stopcount
);

  dtu_pkg::dbg_ctrl_t     ctrl;
  dtu_pkg::halt_capture_t capture;
  dtu_pkg::icount_load_t  icount_load;
  dtu_pkg::icount_t       icount_value;
  logic                   trig_hit;
  logic                   count_done;
  logic                   stepping;
  logic                   resume_step;

  // Core-side views of the debug state
  assign stopcount = ctrl.stopcount;
  assign int_mask  = stepping;

  dtu_csr_file u_csr_file (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .capture        (capture),
    .ctrl           (ctrl),
    .dpc            (dpc),
    .icount_load    (icount_load),
    .icount_value   (icount_value)
  );

  dtu_trigger u_trigger (
    .ctrl     (ctrl),
    .retire   (retire),
    .halted   (halted),
    .trig_hit (trig_hit)
  );

  dtu_icount u_icount (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .icount_load    (icount_load),
    .resume_step    (resume_step),
    .retire_vld     (retire.vld),
    .icount_value   (icount_value),
    .count_done     (count_done),
    .stepping       (stepping)
  );

  dtu_halt_fsm u_halt_fsm (
    .forever_cpuclk  (forever_cpuclk),
    .arst_n          (arst_n),
    .ctrl            (ctrl),
    .retire          (retire),
    .trig_hit        (trig_hit),
    .count_done      (count_done),
    .stepping        (stepping),
    .halt_req_dm     (halt_req_dm),
    .resume_req_dm   (resume_req_dm),
    .core_halt_ack   (core_halt_ack),
    .core_halt_req   (core_halt_req),
    .core_resume_req (core_resume_req),
    .halted          (halted),
    .resume_step     (resume_step),
    .capture         (capture)
  );

endmodule

/* verif/dtu_tb.sv */
`timescale 1ns/1ps
`include "dtu_config.svh"

module dtu_tb;

  localparam int TIMEOUT_CYCLES = 50;
  localparam dtu_pkg::pc_t PC_INC = 4;

  logic             forever_cpuclk;
  logic             arst_n;
  dtu_pkg::wb_req_t wb_req;
  dtu_pkg::wb_rsp_t wb_rsp;
  dtu_pkg::retire_t retire;
  logic             halt_req_dm;
  logic             resume_req_dm;
  logic             core_halt_ack;
  logic             core_halt_req;
  logic             core_resume_req;
  logic             halted;
  dtu_pkg::pc_t     dpc;
  logic             int_mask;
  logic             stopcount;

  int error_count;
  int check_count;

  dtu_top uut (
    .forever_cpuclk  (forever_cpuclk),
    .arst_n          (arst_n),
    .wb_req          (wb_req),
    .wb_rsp          (wb_rsp),
    .retire          (retire),
    .halt_req_dm     (halt_req_dm),
    .resume_req_dm   (resume_req_dm),
    .core_halt_ack   (core_halt_ack),
    .core_halt_req   (core_halt_req),
    .core_resume_req (core_resume_req),
    .halted          (halted),
    .dpc             (dpc),
    .int_mask        (int_mask),
    .stopcount       (stopcount)
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever #2 forever_cpuclk = ~forever_cpuclk;
  end

  // ==============================
  // Helpers
  // ==============================
  task automatic check_value(input string name, input dtu_pkg::xlen_t expected,
                             input dtu_pkg::xlen_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count - errors_before);
    end
  endtask

  // Expected dcsr word built from the field layout
  function automatic dtu_pkg::xlen_t dcsr_value(input logic ebreakm, input logic stop,
                                                input logic [2:0] cause, input logic step,
                                                input logic [1:0] prv);
    dtu_pkg::xlen_t v;
    v                        = '0;
    v[`DTU_DCSR_XDEBUGVER]   = 4'd4;
    v[`DTU_DCSR_EBREAKM]     = ebreakm;
    v[`DTU_DCSR_STOPCOUNT]   = stop;
    v[`DTU_DCSR_CAUSE]       = cause;
    v[`DTU_DCSR_STEP]        = step;
    v[`DTU_DCSR_PRV]         = prv;
    return v;
  endfunction

  function automatic dtu_pkg::pc_t rand_pc();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[`DTU_PC_WIDTH-1:0];
  endfunction

  function automatic dtu_pkg::pc_t next_of(input dtu_pkg::pc_t pc);
    return pc + PC_INC;
  endfunction

  // One classic cycle and then a cycle of stb low before the next one
  task automatic wb_access(input logic we, input dtu_pkg::csr_addr_t adr,
                           input dtu_pkg::xlen_t wdata, output dtu_pkg::xlen_t rdata);
    int cycles;
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr;
    wb_req.dat_w = wdata;
    rdata        = '0;
    cycles       = 0;
    do begin
      @(posedge forever_cpuclk);
      #1;
      cycles++;
    end while (!wb_rsp.ack && cycles < TIMEOUT_CYCLES);
    if (wb_rsp.ack) begin
      rdata = wb_rsp.dat_r;
    end else begin
      error_count++;
      $display("ERROR timeout waiting for Wishbone ack at address %h", adr);
    end
    wb_req = '0;
    @(posedge forever_cpuclk);
    #1;
  endtask

  task automatic wb_write(input dtu_pkg::csr_addr_t adr, input dtu_pkg::xlen_t data);
    dtu_pkg::xlen_t unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input dtu_pkg::csr_addr_t adr, output dtu_pkg::xlen_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic retire_one(input dtu_pkg::pc_t pc, input dtu_pkg::pc_t npc,
                            input logic ebreak);
    retire.vld     = 1'b1;
    retire.pc      = pc;
    retire.next_pc = npc;
    retire.ebreak  = ebreak;
    @(posedge forever_cpuclk);
    #1;
    retire = '0;
  endtask

  // Core side of the halt handshake
  task automatic ack_halt(input string name);
    int cycles;
    cycles = 0;
    while (!core_halt_req && cycles < TIMEOUT_CYCLES) begin
      @(posedge forever_cpuclk);
      #1;
      cycles++;
    end
    if (!core_halt_req) begin
      error_count++;
      $display("ERROR %s: core_halt_req never came", name);
      return;
    end
    core_halt_ack = 1'b1;
    @(posedge forever_cpuclk);
    #1;
    core_halt_ack = 1'b0;
    // halted follows on the ack edge
    check_value(name, 64'd1, dtu_pkg::xlen_t'(halted));
  endtask

  // Resume pulse gives exactly one cycle of core_resume_req
  task automatic resume_core(input string name);
    resume_req_dm = 1'b1;
    @(posedge forever_cpuclk);
    #1;
    resume_req_dm = 1'b0;
    check_value(name, 64'd1, dtu_pkg::xlen_t'(core_resume_req));
    check_value(name, 64'd0, dtu_pkg::xlen_t'(halted));
    @(posedge forever_cpuclk);
    #1;
    check_value(name, 64'd0, dtu_pkg::xlen_t'(core_resume_req));
  endtask

  task automatic check_halt(input string name, input dtu_pkg::xlen_t dcsr_exp,
                            input dtu_pkg::pc_t dpc_exp);
    dtu_pkg::xlen_t rd;
    wb_read(`DTU_CSR_DCSR, rd);
    check_value(name, dcsr_exp, rd);
    wb_read(`DTU_CSR_DPC, rd);
    check_value(name, dtu_pkg::xlen_t'(dpc_exp), rd);
    check_value(name, dtu_pkg::xlen_t'(dpc_exp), dtu_pkg::xlen_t'(dpc));
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic csr_access();
    string          name;
    int             errs;
    dtu_pkg::xlen_t rd;
    dtu_pkg::xlen_t scratch;
    name = "csr_access";
    errs = error_count;
    wb_read(`DTU_CSR_DCSR, rd);
    check_value(name, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_NONE, 1'b0, `DTU_PRV_RESET), rd);
    scratch = {$urandom, $urandom};
    wb_write(`DTU_CSR_DSCRATCH0, scratch);
    wb_read(`DTU_CSR_DSCRATCH0, rd);
    check_value(name, scratch, rd);
    // Only the writable fields stick
    wb_write(`DTU_CSR_DCSR, '1);
    wb_read(`DTU_CSR_DCSR, rd);
    check_value(name, dcsr_value(1'b1, 1'b1, `DTU_CAUSE_NONE, 1'b1, 2'd3), rd);
    check_value(name, 64'd1, dtu_pkg::xlen_t'(stopcount));
    wb_write(`DTU_CSR_DCSR, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_NONE, 1'b0, 2'd3));
    check_value(name, 64'd0, dtu_pkg::xlen_t'(stopcount));
    wb_read(12'h123, rd);
    check_value(name, 64'd0, rd);
    end_test(name, errs);
  endtask

  task automatic halt_request();
    string        name;
    int           errs;
    dtu_pkg::pc_t pc;
    name = "halt_request";
    errs = error_count;
    pc   = '0;
    for (int i = 0; i < 3; i++) begin
      pc = rand_pc();
      retire_one(pc, next_of(pc), 1'b0);
    end
    halt_req_dm = 1'b1;
    ack_halt(name);
    halt_req_dm = 1'b0;
    check_halt(name, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_HALTREQ, 1'b0, 2'd3), next_of(pc));
    resume_core(name);
    end_test(name, errs);
  endtask

  task automatic addr_trigger();
    string        name;
    int           errs;
    dtu_pkg::pc_t trig_pc;
    name    = "addr_trigger";
    errs    = error_count;
    trig_pc = rand_pc();
    wb_write(`DTU_CSR_TDATA2, dtu_pkg::xlen_t'(trig_pc));
    wb_write(`DTU_CSR_TDATA1, 64'd1);
    retire_one(next_of(trig_pc), next_of(next_of(trig_pc)), 1'b0);
    check_value(name, 64'd0, dtu_pkg::xlen_t'(core_halt_req));
    retire_one(trig_pc, next_of(trig_pc), 1'b0);
    check_value(name, 64'd1, dtu_pkg::xlen_t'(core_halt_req));
    ack_halt(name);
    check_halt(name, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_TRIGGER, 1'b0, 2'd3), trig_pc);
    wb_write(`DTU_CSR_TDATA1, 64'd0);
    resume_core(name);
    end_test(name, errs);
  endtask

  task automatic ebreak_halt();
    string        name;
    int           errs;
    dtu_pkg::pc_t pc;
    logic         seen;
    name = "ebreak_halt";
    errs = error_count;
    wb_write(`DTU_CSR_DCSR, dcsr_value(1'b1, 1'b0, `DTU_CAUSE_NONE, 1'b0, 2'd3));
    pc = rand_pc();
    retire_one(pc, next_of(pc), 1'b1);
    ack_halt(name);
    check_halt(name, dcsr_value(1'b1, 1'b0, `DTU_CAUSE_EBREAK, 1'b0, 2'd3), pc);
    wb_write(`DTU_CSR_DCSR, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_NONE, 1'b0, 2'd3));
    resume_core(name);
    // With ebreakm clear the core handles ebreak itself
    pc = rand_pc();
    retire_one(pc, next_of(pc), 1'b1);
    seen = 1'b0;
    for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
      seen = seen | core_halt_req;
      @(posedge forever_cpuclk);
      #1;
    end
    check_value(name, 64'd0, dtu_pkg::xlen_t'(seen));
    end_test(name, errs);
  endtask

  task automatic single_step();
    string          name;
    int             errs;
    dtu_pkg::pc_t   pc;
    dtu_pkg::xlen_t rd;
    name = "single_step";
    errs = error_count;
    halt_req_dm = 1'b1;
    ack_halt(name);
    halt_req_dm = 1'b0;
    wb_write(`DTU_CSR_DCSR, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_NONE, 1'b1, 2'd3));
    resume_core(name);
    check_value(name, 64'd1, dtu_pkg::xlen_t'(int_mask));
    pc = rand_pc();
    retire_one(pc, next_of(pc), 1'b0);
    ack_halt(name);
    check_halt(name, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_STEP, 1'b1, 2'd3), next_of(pc));
    check_value(name, 64'd0, dtu_pkg::xlen_t'(int_mask));

    // icount of five without stepping
    wb_write(`DTU_CSR_DCSR, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_NONE, 1'b0, 2'd3));
    wb_write(`DTU_CSR_ICOUNT, 64'd5);
    wb_read(`DTU_CSR_ICOUNT, rd);
    check_value(name, 64'd5, rd);
    resume_core(name);
    check_value(name, 64'd0, dtu_pkg::xlen_t'(int_mask));
    for (int i = 0; i < 4; i++) begin
      pc = rand_pc();
      retire_one(pc, next_of(pc), 1'b0);
    end
    check_value(name, 64'd0, dtu_pkg::xlen_t'(core_halt_req));
    pc = rand_pc();
    retire_one(pc, next_of(pc), 1'b0);
    ack_halt(name);
    check_halt(name, dcsr_value(1'b0, 1'b0, `DTU_CAUSE_TRIGGER, 1'b0, 2'd3), next_of(pc));
    resume_core(name);
    end_test(name, errs);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    void'($urandom(32'hdcf4));
    error_count   = 0;
    check_count   = 0;
    arst_n        = 1'b0;
    wb_req        = '0;
    retire        = '0;
    halt_req_dm   = 1'b0;
    resume_req_dm = 1'b0;
    core_halt_ack = 1'b0;
    repeat (8) @(posedge forever_cpuclk);
    #1;
    arst_n = 1'b1;
    @(posedge forever_cpuclk);
    #1;

    csr_access();
    halt_request();
    addr_trigger();
    ebreak_halt();
    single_step();

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+include
src/dtu_pkg.sv
src/dtu_csr_file.sv
src/dtu_trigger.sv
src/dtu_icount.sv
src/dtu_halt_fsm.sv
src/dtu_top.sv
verif/dtu_tb.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module dtu_tb \
		-Mdir obj_dir -o dtu_tb_sim

run: build
	@out="$$(./obj_dir/dtu_tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing -f sim.f --top-module dtu_tb

clean:
	rm -rf obj_dir
